/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_regread_exec
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
prf_pkg.sv
phys_regfile.sv
issue_lane.sv
int_alu.sv
lsu_scratch.sv
regread_exec_top.sv
tb_regread_exec.sv

/* int_alu.sv */
module int_alu import prf_pkg::*; (
   input  logic       exec_valid,
   input  int_issue_t issue,
   input  xlen_t      op_a,
   input  xlen_t      op_b,
   output wb_t        wb
);

   xlen_t      src_b;
   logic [4:0] shamt;
   xlen_t      result;

   assign src_b = issue.use_imm ? {{(XLEN-12){issue.imm[11]}}, issue.imm} : op_b;
   assign shamt = src_b[4:0];

   always_comb begin
      case (issue.op)
         ALU_ADD: result = op_a + src_b;
         ALU_SUB: result = op_a - src_b;
         ALU_AND: result = op_a & src_b;
         ALU_OR:  result = op_a | src_b;
         ALU_XOR: result = op_a ^ src_b;
         ALU_SLL: result = op_a << shamt;
         ALU_SRL: result = op_a >> shamt;
         // Signed compare
         ALU_SLT: result = {{(XLEN-1){1'b0}}, ($signed(op_a) < $signed(src_b))};
         default: result = '0;
      endcase
   end

   assign wb.valid = exec_valid;
   assign wb.prd   = issue.prd;
   assign wb.data  = result;

endmodule

/* issue_lane.sv */
module issue_lane import prf_pkg::*; #(
   parameter type issue_t = int_issue_t
) (
   input  logic   clk,
   input  logic   reset_n,
   input  logic   req,
   input  issue_t payload,
   input  xlen_t  rs1_data,
   input  xlen_t  rs2_data,
   output logic   ack,
   output logic   exec_valid,
   output issue_t exec_payload,
   output xlen_t  op_a,
   output xlen_t  op_b
);

   typedef enum logic [1:0] {
      LANE_IDLE,
      LANE_EXEC,
      LANE_ACKED
   } lane_state_e;

   lane_state_e state;
   lane_state_e state_nxt;
   logic        accept;

   assign accept = (state == LANE_IDLE) && req;

   always_comb begin
      state_nxt = state;
      case (state)
         LANE_IDLE: begin
            if (req) begin
               state_nxt = LANE_EXEC;
            end
         end
         // Result lands in the register file on this edge
         LANE_EXEC: begin
            state_nxt = LANE_ACKED;
         end
         LANE_ACKED: begin
            if (!req) begin
               state_nxt = LANE_IDLE;
            end
         end
         default: begin
            state_nxt = LANE_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state <= LANE_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // Operands read combinationally in the accept cycle
   always_ff @(posedge clk) begin
      if (accept) begin
         exec_payload <= payload;
         op_a         <= rs1_data;
         op_b         <= rs2_data;
      end
   end

   assign exec_valid = (state == LANE_EXEC);
   assign ack        = (state == LANE_ACKED);

endmodule

/* lsu_scratch.sv */
module lsu_scratch import prf_pkg::*; (
   input  logic       clk,
   input  logic       reset_n,
   input  logic       exec_valid,
   input  mem_issue_t issue,
   input  xlen_t      op_a,
   input  xlen_t      op_b,
   output wb_t        wb
);

   xlen_t                offset;
   xlen_t                addr;
   logic [LSU_IDX_W-1:0] word_idx;
   xlen_t                mem [LSU_WORDS];

   assign offset   = {{(XLEN-12){issue.imm[11]}}, issue.imm};
   assign addr     = op_a + offset;
   // Word aligned with upper address bits ignored
   assign word_idx = addr[LSU_IDX_W+1:2];

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < LSU_WORDS; i++) begin
            mem[i] <= '0;
         end
      end else if (exec_valid && issue.is_store) begin
         mem[word_idx] <= op_b;
      end
   end

   // Stores never wake anything up
   assign wb.valid = exec_valid && !issue.is_store;
   assign wb.prd   = issue.prd;
   assign wb.data  = mem[word_idx];

endmodule

/* phys_regfile.sv */
module phys_regfile import prf_pkg::*; (
   input  logic      clk,
   input  logic      reset_n,
   input  prf_addr_t rd_addr [PRF_RD_PORTS],
   output xlen_t     rd_data [PRF_RD_PORTS],
   input  wb_t       wr      [PRF_WR_PORTS]
);

   xlen_t regs [PRF_NUM];

   // Later ports override earlier ones on the same prd
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < PRF_NUM; i++) begin
            regs[i] <= '0;
         end
      end else begin
         for (int p = 0; p < PRF_WR_PORTS; p++) begin
            if (wr[p].valid && (wr[p].prd != '0)) begin
               regs[wr[p].prd] <= wr[p].data;
            end
         end
      end
   end

   // p0 is hard zero
   always_comb begin
      for (int r = 0; r < PRF_RD_PORTS; r++) begin
         if (rd_addr[r] == '0) begin
            rd_data[r] = '0;
         end else begin
            rd_data[r] = regs[rd_addr[r]];
         end
      end
   end

endmodule

/* prf_patterns.txt */
# int0/int1: op prs1 prs2 prd use_imm imm expected | pair: iq0 fields then iq1 fields
# fill: prd data | mem: is_store prs1 prs2 prd imm expected (all fields hex)
int0 0 05 06 07 0 000 00000000
fill 01 00000010
fill 02 fffffff0
fill 03 12345678
fill 04 0000000c
fill 05 00000003
int0 0 01 03 08 0 000 12345688
int1 1 03 01 09 0 000 12345668
int0 2 03 00 0a 1 f0f 12345608
int1 3 01 00 0b 1 801 fffff811
int0 4 03 00 0c 1 0ff 12345687
int1 5 01 05 0d 0 000 00000080
int0 6 02 05 0e 0 000 1ffffffe
int1 7 02 01 0f 0 000 00000001
int0 7 01 02 10 0 000 00000000
int1 5 03 00 11 1 024 23456780
int0 0 02 00 12 1 7ff 000007ef
pair 0 08 09 19 0 000 2468acf0 1 0d 0f 1a 0 000 0000007f
int1 4 19 1a 1b 0 000 2468ac8f
fill 00 deadbeef
int0 0 00 00 1f 0 000 00000000
int1 0 01 00 00 1 005 00000015
int0 3 00 00 20 0 000 00000000
mem 1 04 03 00 004 00000000
mem 1 04 0d 00 ff8 00000000
mem 0 02 00 21 020 12345678
mem 0 01 00 22 ff4 00000080
mem 0 04 00 23 010 00000000
int0 0 21 22 24 0 000 123456f8

/* prf_pkg.sv */
package prf_pkg;

   localparam int PRF_NUM      = 64;
   localparam int PRF_WIDTH    = 6;
   localparam int XLEN         = 32;
   localparam int LSU_WORDS    = 16;
   localparam int LSU_IDX_W    = $clog2(LSU_WORDS);
   localparam int PRF_RD_PORTS = 6;
   localparam int PRF_WR_PORTS = 4;

   typedef logic [PRF_WIDTH-1:0] prf_addr_t;
   typedef logic [XLEN-1:0]      xlen_t;

   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_XOR = 3'd4,
      ALU_SLL = 3'd5,
      ALU_SRL = 3'd6,
      ALU_SLT = 3'd7
   } alu_op_e;

   typedef struct packed {
      alu_op_e     op;
      prf_addr_t   prs1;
      prf_addr_t   prs2;
      prf_addr_t   prd;
      logic        use_imm;
      logic [11:0] imm;
   } int_issue_t;

   typedef struct packed {
      logic        is_store;
      prf_addr_t   prs1;
      // Store data source
      prf_addr_t   prs2;
      prf_addr_t   prd;
      logic [11:0] imm;
   } mem_issue_t;

   // Register-file write and wakeup broadcast
   typedef struct packed {
      logic      valid;
      prf_addr_t prd;
      xlen_t     data;
   } wb_t;

endpackage

/* regread_exec_top.sv */
module regread_exec_top import prf_pkg::*; (
   input  logic       clk,
   input  logic       reset_n,
   input  logic       iq0_req,
   input  logic       iq1_req,
   input  logic       mem_req,
   input  int_issue_t iq0_issue,
   input  int_issue_t iq1_issue,
   input  mem_issue_t mem_issue,
   input  wb_t        wb_ext,
   output logic       iq0_ack,
   output logic       iq1_ack,
   output logic       mem_ack,
   output wb_t        wb_iq0,
   output wb_t        wb_iq1,
   output wb_t        wb_mem
);

   prf_addr_t  rd_addr [PRF_RD_PORTS];
   xlen_t      rd_data [PRF_RD_PORTS];
   wb_t        wr      [PRF_WR_PORTS];

   logic       iq0_exec_valid;
   logic       iq1_exec_valid;
   logic       mem_exec_valid;
   int_issue_t iq0_exec_issue;
   int_issue_t iq1_exec_issue;
   mem_issue_t mem_exec_issue;
   xlen_t      iq0_op_a;
   xlen_t      iq0_op_b;
   xlen_t      iq1_op_a;
   xlen_t      iq1_op_b;
   xlen_t      mem_op_a;
   xlen_t      mem_op_b;

   // Two read ports per lane, in lane order
   assign rd_addr[0] = iq0_issue.prs1;
   assign rd_addr[1] = iq0_issue.prs2;
   assign rd_addr[2] = iq1_issue.prs1;
   assign rd_addr[3] = iq1_issue.prs2;
   assign rd_addr[4] = mem_issue.prs1;
   assign rd_addr[5] = mem_issue.prs2;

   // External writeback on the highest priority port
   assign wr[0] = wb_iq0;
   assign wr[1] = wb_iq1;
   assign wr[2] = wb_mem;
   assign wr[3] = wb_ext;

   phys_regfile prf0 (
      .clk     (clk),
      .reset_n (reset_n),
      .rd_addr (rd_addr),
      .rd_data (rd_data),
      .wr      (wr)
   );

   issue_lane #(.issue_t(int_issue_t)) lane_iq0 (
      .clk          (clk),
      .reset_n      (reset_n),
      .req          (iq0_req),
      .payload      (iq0_issue),
      .rs1_data     (rd_data[0]),
      .rs2_data     (rd_data[1]),
      .ack          (iq0_ack),
      .exec_valid   (iq0_exec_valid),
      .exec_payload (iq0_exec_issue),
      .op_a         (iq0_op_a),
      .op_b         (iq0_op_b)
   );

   issue_lane #(.issue_t(int_issue_t)) lane_iq1 (
      .clk          (clk),
      .reset_n      (reset_n),
      .req          (iq1_req),
      .payload      (iq1_issue),
      .rs1_data     (rd_data[2]),
      .rs2_data     (rd_data[3]),
      .ack          (iq1_ack),
      .exec_valid   (iq1_exec_valid),
      .exec_payload (iq1_exec_issue),
      .op_a         (iq1_op_a),
      .op_b         (iq1_op_b)
   );

   issue_lane #(.issue_t(mem_issue_t)) lane_mem (
      .clk          (clk),
      .reset_n      (reset_n),
      .req          (mem_req),
      .payload      (mem_issue),
      .rs1_data     (rd_data[4]),
      .rs2_data     (rd_data[5]),
      .ack          (mem_ack),
      .exec_valid   (mem_exec_valid),
      .exec_payload (mem_exec_issue),
      .op_a         (mem_op_a),
      .op_b         (mem_op_b)
   );

   int_alu alu0 (
      .exec_valid (iq0_exec_valid),
      .issue      (iq0_exec_issue),
      .op_a       (iq0_op_a),
      .op_b       (iq0_op_b),
      .wb         (wb_iq0)
   );

   int_alu alu1 (
      .exec_valid (iq1_exec_valid),
      .issue      (iq1_exec_issue),
      .op_a       (iq1_op_a),
      .op_b       (iq1_op_b),
      .wb         (wb_iq1)
   );

   lsu_scratch lsu0 (
      .clk        (clk),
      .reset_n    (reset_n),
      .exec_valid (mem_exec_valid),
      .issue      (mem_exec_issue),
      .op_a       (mem_op_a),
      .op_b       (mem_op_b),
      .wb         (wb_mem)
   );

endmodule

/* tb_regread_exec.sv */
module tb_regread_exec import prf_pkg::*; ();

   logic       clk;
   logic       reset_n;
   logic       iq0_req;
   logic       iq1_req;
   logic       mem_req;
   int_issue_t iq0_issue;
   int_issue_t iq1_issue;
   mem_issue_t mem_issue;
   wb_t        wb_ext;
   logic       iq0_ack;
   logic       iq1_ack;
   logic       mem_ack;
   wb_t        wb_iq0;
   wb_t        wb_iq1;
   wb_t        wb_mem;

   integer seed;
   int     fd;
   int     code;
   int     max_wait_cycles = 50;
   string  kind;
   string  skipped;
   xlen_t  f [14];

   regread_exec_top dut0 (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic abort_run();
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input xlen_t expected, input xlen_t actual);
      if (expected !== actual) begin
         $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
                  $time, name, expected, actual);
         abort_run();
      end
   endtask

   function automatic wb_t lane_wb(input int lane);
      case (lane)
         0: return wb_iq0;
         1: return wb_iq1;
         default: return wb_mem;
      endcase
   endfunction

   function automatic logic lane_ack(input int lane);
      case (lane)
         0: return iq0_ack;
         1: return iq1_ack;
         default: return mem_ack;
      endcase
   endfunction

   function automatic string lane_name(input int lane);
      case (lane)
         0: return "iq0";
         1: return "iq1";
         default: return "mem";
      endcase
   endfunction

   task automatic set_req(input int lane, input logic value);
      case (lane)
         0: iq0_req = value;
         1: iq1_req = value;
         default: mem_req = value;
      endcase
   endtask

   // One full four-phase transaction on a lane
   task automatic run_lane(input int lane, input logic exp_valid, input xlen_t exp_prd,
                           input xlen_t exp_data);
      wb_t   rec;
      wb_t   seen_rec;
      int    seen;
      int    valid_cycle;
      int    cycles;
      int    hold;
      string name;
      name = lane_name(lane);
      seen = 0;
      valid_cycle = 0;
      cycles = 0;
      seen_rec = '0;
      set_req(lane, 1'b1);
      do begin
         @(negedge clk);
         cycles++;
         rec = lane_wb(lane);
         if (rec.valid) begin
            seen++;
            seen_rec = rec;
            valid_cycle = cycles;
         end
         if (cycles > max_wait_cycles) begin
            $display("Timeout: lane %s raised no ack within %0d cycles", name, max_wait_cycles);
            abort_run();
         end
      end while (!lane_ack(lane));
      check_value({name, " wakeup count"}, {31'b0, exp_valid}, xlen_t'(seen));
      if (exp_valid) begin
         check_value({name, " wakeup prd"}, exp_prd, xlen_t'(seen_rec.prd));
         check_value({name, " wakeup data"}, exp_data, seen_rec.data);
         // Wakeup sits in the cycle just before ack
         check_value({name, " ack cycle"}, xlen_t'(valid_cycle + 1), xlen_t'(cycles));
      end
      hold = {$random(seed)} % 4;
      repeat (hold) begin
         @(negedge clk);
         rec = lane_wb(lane);
         check_value({name, " ack while held"}, 32'd1, {31'b0, lane_ack(lane)});
         check_value({name, " wakeup valid while held"}, 32'd0, {31'b0, rec.valid});
      end
      set_req(lane, 1'b0);
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
         rec = lane_wb(lane);
         check_value({name, " wakeup valid after req"}, 32'd0, {31'b0, rec.valid});
         if (cycles > max_wait_cycles) begin
            $display("Timeout: lane %s kept ack high after req dropped", name);
            abort_run();
         end
      end while (lane_ack(lane));
   endtask

   task automatic read_fields(input int count);
      for (int i = 0; i < count; i++) begin
         code = $fscanf(fd, "%h", f[i]);
         if (code != 1) begin
            $display("Pattern line of kind %s has too few fields", kind);
            abort_run();
         end
      end
   endtask

   function automatic int_issue_t int_from_fields(input int base);
      int_issue_t t;
      t.op      = alu_op_e'(f[base][2:0]);
      t.prs1    = f[base+1][5:0];
      t.prs2    = f[base+2][5:0];
      t.prd     = f[base+3][5:0];
      t.use_imm = f[base+4][0];
      t.imm     = f[base+5][11:0];
      return t;
   endfunction

   task automatic run_pattern();
      if (kind == "fill") begin
         read_fields(2);
         wb_ext = '{valid: 1'b1, prd: f[0][5:0], data: f[1]};
         @(negedge clk);
         wb_ext = '0;
      end else if (kind == "int0") begin
         read_fields(7);
         iq0_issue = int_from_fields(0);
         run_lane(0, 1'b1, f[3], f[6]);
      end else if (kind == "int1") begin
         read_fields(7);
         iq1_issue = int_from_fields(0);
         run_lane(1, 1'b1, f[3], f[6]);
      end else if (kind == "pair") begin
         read_fields(14);
         iq0_issue = int_from_fields(0);
         iq1_issue = int_from_fields(7);
         fork
            run_lane(0, 1'b1, f[3], f[6]);
            run_lane(1, 1'b1, f[10], f[13]);
         join
      end else if (kind == "mem") begin
         read_fields(6);
         mem_issue = '{is_store: f[0][0], prs1: f[1][5:0], prs2: f[2][5:0],
                       prd: f[3][5:0], imm: f[4][11:0]};
         run_lane(2, !f[0][0], f[3], f[5]);
      end else begin
         $display("Unknown pattern kind %s", kind);
         abort_run();
      end
   endtask

   initial begin
      seed = 32'h85f6_35d7;
      reset_n = 1'b0;
      iq0_req = 1'b0;
      iq1_req = 1'b0;
      mem_req = 1'b0;
      iq0_issue = '0;
      iq1_issue = '0;
      mem_issue = '0;
      wb_ext = '0;
      repeat (5) @(negedge clk);
      reset_n = 1'b1;
      check_value("iq0_ack", 32'd0, {31'b0, iq0_ack});
      check_value("iq1_ack", 32'd0, {31'b0, iq1_ack});
      check_value("mem_ack", 32'd0, {31'b0, mem_ack});
      check_value("wb_iq0.valid", 32'd0, {31'b0, wb_iq0.valid});
      check_value("wb_iq1.valid", 32'd0, {31'b0, wb_iq1.valid});
      check_value("wb_mem.valid", 32'd0, {31'b0, wb_mem.valid});
      fd = $fopen("prf_patterns.txt", "r");
      if (fd == 0) begin
         $display("Could not open the pattern file prf_patterns.txt");
         abort_run();
      end
      while (!$feof(fd)) begin
         code = $fscanf(fd, "%s", kind);
         if (code == 1 && kind == "#") begin
            code = $fgets(skipped, fd);
         end else if (code == 1) begin
            run_pattern();
            repeat ({$random(seed)} % 4) @(negedge clk);
         end
      end
      $fclose(fd);
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule
